/* design/pu_defs.svh */
`ifndef PU_DEFS_SVH
`define PU_DEFS_SVH

// Lane array.
`define PU_LANES      4

// Datapath widths.
`define PU_ACT_W      8
`define PU_WGT_W      8
`define PU_ACC_W      24

// Layer configuration.
`define PU_LAYER_W    4
`define PU_MAX_LAYERS 16
`define PU_IC_W       8
`define PU_GRP_W      4
`define PU_SHIFT_W    4

// Weight buffer, one word holds the weights of all lanes.
`define PU_WADDR_W    8

`endif

/* design/pu_pkg.sv */
`include "pu_defs.svh"

package pu_pkg;

    // Datapath values.
    typedef logic signed [`PU_ACT_W-1:0] act_t;
    typedef logic signed [`PU_WGT_W-1:0] wgt_t;
    typedef logic signed [`PU_ACC_W-1:0] acc_t;

    // One weight buffer word, lane 0 in the low bits.
    typedef logic [`PU_LANES*`PU_WGT_W-1:0] wvec_t;

    // Sequencing.
    typedef logic [`PU_LAYER_W-1:0] layer_t;
    typedef logic [`PU_IC_W-1:0]    ic_t;
    typedef logic [`PU_GRP_W-1:0]   grp_t;   // Group index and group count.
    typedef logic [`PU_SHIFT_W-1:0] shift_t;
    typedef logic [`PU_WADDR_W-1:0] waddr_t;

    // Table word: {ic count, group count, shift}.
    typedef logic [`PU_IC_W+`PU_GRP_W+`PU_SHIFT_W-1:0] cfg_t;

    // Layer controller FSM.
    typedef enum logic [1:0] {
        IDLE,   // Waiting for start.
        BUSY,   // Accepting activations.
        DRAIN   // Last results still in the collector.
    } ctrl_state_t;

endpackage

/* design/pe_bus_if.sv */
interface pe_bus_if;
    import pu_pkg::*;

    logic   valid;   // One strobe per activation.
    act_t   act;
    wvec_t  wvec;    // Weights of all lanes.
    logic   first;   // Load the accumulator instead of adding.
    logic   last;    // Closes the output-channel group.
    shift_t shift;
    layer_t layer;
    grp_t   grp;

    // Distributor side.
    modport source (
        output valid, act, wvec, first, last, shift, layer, grp
    );

    // Lanes and collector.
    modport sink (
        input valid, act, wvec, first, last, shift, layer, grp
    );

endinterface

/* design/pu_controller.sv */
`include "pu_defs.svh"

module pu_controller (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  pu_pkg::layer_t num_layers,
    input  logic           cfg_we,
    input  pu_pkg::layer_t cfg_addr,
    input  pu_pkg::cfg_t   cfg_data,
    input  logic           in_valid,
    output logic           step,
    output logic           first,
    output logic           last,
    output pu_pkg::shift_t shift,
    output pu_pkg::layer_t layer,
    output pu_pkg::grp_t   grp,
    input  logic           coll_busy,
    output logic           busy,
    output logic           done
);
    import pu_pkg::*;

    cfg_t        cfg_mem [`PU_MAX_LAYERS];   // Per-layer configuration table.
    cfg_t        cfg_cur;
    ic_t         ic_num;
    grp_t        grp_num;
    ctrl_state_t state;
    ctrl_state_t state_next;
    ic_t         ic_cnt;
    grp_t        grp_cnt;
    layer_t      layer_cnt;
    layer_t      layer_num;                  // Layer count of the current run.
    logic        ic_last;
    logic        grp_last;
    logic        layer_last;

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            cfg_mem[cfg_addr] <= cfg_data;
        end
    end

    // Fields of the active layer.
    assign cfg_cur = cfg_mem[layer_cnt];
    assign ic_num  = cfg_cur[`PU_GRP_W+`PU_SHIFT_W +: `PU_IC_W];
    assign grp_num = cfg_cur[`PU_SHIFT_W +: `PU_GRP_W];
    assign shift   = cfg_cur[0 +: `PU_SHIFT_W];

    assign ic_last    = (ic_cnt == ic_num - 1'b1);
    assign grp_last   = (grp_cnt == grp_num - 1'b1);
    assign layer_last = (layer_cnt == layer_num - 1'b1);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) state_next = BUSY;
            end
            BUSY: begin
                if (step && ic_last && grp_last && layer_last) state_next = DRAIN;
            end
            DRAIN: begin
                if (!coll_busy) state_next = IDLE;   // Last lane has left.
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            layer_num <= num_layers;
        end
    end

    // Channel, group and layer counters, one step per accepted input.
    always_ff @(posedge clk) begin
        if (reset || (state == IDLE && start)) begin
            ic_cnt    <= '0;
            grp_cnt   <= '0;
            layer_cnt <= '0;
        end else if (step) begin
            if (!ic_last) begin
                ic_cnt <= ic_cnt + 1'b1;
            end else begin
                ic_cnt <= '0;
                if (!grp_last) begin
                    grp_cnt <= grp_cnt + 1'b1;
                end else begin
                    grp_cnt   <= '0;
                    layer_cnt <= layer_last ? '0 : layer_cnt + 1'b1;
                end
            end
        end
    end

    assign step  = in_valid && (state == BUSY);   // Inputs outside BUSY are dropped.
    assign first = (ic_cnt == '0);
    assign last  = ic_last;
    assign layer = layer_cnt;
    assign grp   = grp_cnt;

    assign busy = (state != IDLE);
    assign done = (state == DRAIN) && !coll_busy;

endmodule

/* design/act_distributor.sv */
`include "pu_defs.svh"

module act_distributor (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           step,
    input  logic           first,
    input  logic           last,
    input  pu_pkg::shift_t shift,
    input  pu_pkg::layer_t layer,
    input  pu_pkg::grp_t   grp,
    input  logic           wgt_we,
    input  pu_pkg::waddr_t wgt_addr,
    input  pu_pkg::wvec_t  wgt_data,
    input  pu_pkg::act_t   in_act,
    pe_bus_if.source       bus
);
    import pu_pkg::*;

    wvec_t  wbuf [2**`PU_WADDR_W];   // Weight words in consumption order.
    waddr_t wptr;                    // Next word to read.

    always_ff @(posedge clk) begin
        if (wgt_we) begin
            wbuf[wgt_addr] <= wgt_data;
        end
    end

    // The pointer runs across all groups and layers of a run.
    always_ff @(posedge clk) begin
        if (reset) begin
            wptr <= '0;
        end else if (start) begin
            wptr <= '0;
        end else if (step) begin
            wptr <= wptr + 1'b1;
        end
    end

    // Strobes of the lane bus.
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.valid <= 1'b0;
            bus.first <= 1'b0;
            bus.last  <= 1'b0;
        end else begin
            bus.valid <= step;
            bus.first <= step && first;
            bus.last  <= step && last;
        end
    end

    // Activation, weights and tags, held between steps.
    always_ff @(posedge clk) begin
        if (step) begin
            bus.act   <= in_act;
            bus.wvec  <= wbuf[wptr];   // Synchronous buffer read.
            bus.shift <= shift;
            bus.layer <= layer;
            bus.grp   <= grp;
        end
    end

endmodule

/* design/mac_lane.sv */
`include "pu_defs.svh"

module mac_lane #(
    parameter int LANE_IDX = 0
) (
    input  logic         clk,
    input  logic         reset,
    pe_bus_if.sink       bus,
    output logic         res_valid,
    output pu_pkg::act_t res_data
);
    import pu_pkg::*;

    // Output range of a signed activation.
    localparam acc_t SAT_MAX = acc_t'((1 << (`PU_ACT_W - 1)) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(1 << (`PU_ACT_W - 1)));

    wgt_t wgt;
    acc_t prod;
    acc_t acc;
    acc_t acc_next;
    acc_t acc_shr;

    assign wgt      = wgt_t'(bus.wvec[LANE_IDX*`PU_WGT_W +: `PU_WGT_W]);   // Own slice.
    assign prod     = acc_t'(bus.act) * acc_t'(wgt);
    assign acc_next = bus.first ? prod : acc + prod;
    assign acc_shr  = acc_next >>> bus.shift;   // Arithmetic, keeps the sign.

    always_ff @(posedge clk) begin
        if (bus.valid) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= bus.valid && bus.last;
        end
    end

    // Saturate the scaled sum at the end of the group.
    always_ff @(posedge clk) begin
        if (bus.valid && bus.last) begin
            if (acc_shr > SAT_MAX) res_data <= act_t'(SAT_MAX);
            else if (acc_shr < SAT_MIN) res_data <= act_t'(SAT_MIN);
            else res_data <= act_t'(acc_shr);
        end
    end

endmodule

/* design/result_collector.sv */
`include "pu_defs.svh"

module result_collector (
    input  logic                          clk,
    input  logic                          reset,
    pe_bus_if.sink                        bus,
    input  logic [`PU_LANES-1:0]          res_valid,
    input  pu_pkg::act_t                  res_data [`PU_LANES],
    output logic                          out_valid,
    output pu_pkg::act_t                  out_data,
    output logic [$clog2(`PU_LANES)-1:0]  out_lane,
    output pu_pkg::layer_t                out_layer,
    output pu_pkg::grp_t                  out_grp,
    output logic                          busy
);
    import pu_pkg::*;

    localparam int                LIDX_W    = $clog2(`PU_LANES);
    localparam logic [LIDX_W-1:0] LAST_LANE = LIDX_W'(`PU_LANES - 1);

    act_t              res_q [`PU_LANES];   // Results being sent out.
    layer_t            layer_p;             // Tags of the group still in the lanes.
    grp_t              grp_p;
    logic              pend;
    logic              active;
    logic [LIDX_W-1:0] idx;

    // A closed group waits here until the lanes report.
    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
        end else if (bus.valid && bus.last) begin
            pend <= 1'b1;
        end else if (res_valid[0]) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid && bus.last) begin
            layer_p <= bus.layer;
            grp_p   <= bus.grp;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `PU_LANES; k++) begin
            if (res_valid[k]) res_q[k] <= res_data[k];
        end
        if (res_valid[0]) begin
            out_layer <= layer_p;   // Tags follow the results out.
            out_grp   <= grp_p;
        end
    end

    // One lane per cycle, lane 0 first.
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (res_valid[0]) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            if (idx == LAST_LANE) active <= 1'b0;
            idx <= (idx == LAST_LANE) ? '0 : idx + 1'b1;
        end
    end

    assign out_valid = active;
    assign out_data  = res_q[idx];
    assign out_lane  = idx;
    assign busy      = pend || active || (bus.valid && bus.last);

endmodule

/* design/pu_top.sv */
`include "pu_defs.svh"

module pu_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cfg_we,
    input  pu_pkg::layer_t                cfg_addr,
    input  pu_pkg::cfg_t                  cfg_data,
    input  logic                          wgt_we,
    input  pu_pkg::waddr_t                wgt_addr,
    input  pu_pkg::wvec_t                 wgt_data,
    input  logic                          start,
    input  pu_pkg::layer_t                num_layers,
    input  logic                          in_valid,
    input  pu_pkg::act_t                  in_act,
    output logic                          out_valid,
    output pu_pkg::act_t                  out_data,
    output logic [$clog2(`PU_LANES)-1:0]  out_lane,
    output pu_pkg::layer_t                out_layer,
    output pu_pkg::grp_t                  out_grp,
    output logic                          done,
    output logic                          busy
);
    import pu_pkg::*;

    logic                 step;
    logic                 first;
    logic                 last;
    shift_t               shift;
    layer_t               layer;
    grp_t                 grp;
    logic                 coll_busy;
    logic                 run_start;
    logic [`PU_LANES-1:0] res_valid;
    act_t                 res_data [`PU_LANES];

    pe_bus_if bus ();

    assign run_start = start && !busy;   // Only a start from idle restarts the weights.

    pu_controller ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .num_layers (num_layers),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .in_valid   (in_valid),
        .step       (step),
        .first      (first),
        .last       (last),
        .shift      (shift),
        .layer      (layer),
        .grp        (grp),
        .coll_busy  (coll_busy),
        .busy       (busy),
        .done       (done)
    );

    act_distributor dist_i (
        .clk      (clk),
        .reset    (reset),
        .start    (run_start),
        .step     (step),
        .first    (first),
        .last     (last),
        .shift    (shift),
        .layer    (layer),
        .grp      (grp),
        .wgt_we   (wgt_we),
        .wgt_addr (wgt_addr),
        .wgt_data (wgt_data),
        .in_act   (in_act),
        .bus      (bus.source)
    );

    for (genvar i = 0; i < `PU_LANES; i++) begin : g_lane
        mac_lane #(
            .LANE_IDX (i)
        ) lane_i (
            .clk       (clk),
            .reset     (reset),
            .bus       (bus.sink),
            .res_valid (res_valid[i]),
            .res_data  (res_data[i])
        );
    end

    result_collector coll_i (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus.sink),
        .res_valid (res_valid),
        .res_data  (res_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_lane  (out_lane),
        .out_layer (out_layer),
        .out_grp   (out_grp),
        .busy      (coll_busy)
    );

endmodule

/* tb/pu_tb.sv */
`include "pu_defs.svh"

module pu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pu_pkg::*;

    // Activations of all tests.
    localparam int ACT_TOTAL   = 16 + 8 + 40 + 33 + 24 + 8;
    localparam int WATCHDOG_NS = (3 * ACT_TOTAL + 200) * 4;   // Weight write and gap per activation.

    typedef struct {
        int data;
        int lane;
        int layer;
        int grp;
        int at_cycle;   // Clock edge that must sample this beat.
    } beat_t;

    logic                         clk;
    logic                         reset;
    logic                         cfg_we;
    layer_t                       cfg_addr;
    cfg_t                         cfg_data;
    logic                         wgt_we;
    waddr_t                       wgt_addr;
    wvec_t                        wgt_data;
    logic                         start;
    layer_t                       num_layers;
    logic                         in_valid;
    act_t                         in_act;
    logic                         out_valid;
    act_t                         out_data;
    logic [$clog2(`PU_LANES)-1:0] out_lane;
    layer_t                       out_layer;
    grp_t                         out_grp;
    logic                         done;
    logic                         busy;

    logic [15:0] lfsr = 16'd52550;
    beat_t       exp_q [$];
    wvec_t       wmem [2**`PU_WADDR_W];   // Weights in consumption order.
    int          cfg_ic [`PU_MAX_LAYERS];
    int          cfg_grp [`PU_MAX_LAYERS];
    int          cfg_sh [`PU_MAX_LAYERS];
    int          cyc = 0;
    int          done_edge = -1;
    int          done_count = 0;
    int          err_count = 0;
    int          err_mark = 0;
    int          pass_tests = 0;
    int          fail_tests = 0;
    bit          in_run = 0;
    string       test_name = "reset";

    pu_top pu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the simulation did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // One output bit per step of a 16-bit Fibonacci LFSR.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_signed(input int n);
        logic [31:0] r;
        r = rand_bits(n);
        return r[n-1] ? int'(r) - (1 << n) : int'(r);
    endfunction

    // Arithmetic shift, then clip to the signed activation range.
    function automatic int sat_shift(input int sum, input int sh);
        int v;
        v = sum >>> sh;
        if (v > (1 << (`PU_ACT_W - 1)) - 1) return (1 << (`PU_ACT_W - 1)) - 1;
        if (v < -(1 << (`PU_ACT_W - 1))) return -(1 << (`PU_ACT_W - 1));
        return v;
    endfunction

    task automatic report_mismatch(input string what, input int expv, input int actv);
        err_count++;
        $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expv, actv);
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = err_count;
    endtask

    task automatic end_test();
        if (err_count == err_mark) begin
            pass_tests++;
            $display("%s: ok", test_name);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", test_name, err_count - err_mark);
        end
    endtask

    task automatic set_layer(input int l, input int ic, input int grp, input int sh);
        cfg_ic[l]  = ic;
        cfg_grp[l] = grp;
        cfg_sh[l]  = sh;
    endtask

    // Loads config and weights, runs the layers and builds the expected beats.
    task automatic run_layers(input int n_layers, input int act_bits, input int wgt_bits,
                              input bit clip_first, input bit gaps, input bit restart_mid);
        int    ptr;
        int    a;
        int    acc [`PU_LANES];
        beat_t b;
        wvec_t w;
        for (int l = 0; l < n_layers; l++) begin
            @(negedge clk);
            cfg_we   = 1'b1;
            cfg_addr = layer_t'(l);
            cfg_data = {8'(cfg_ic[l]), 4'(cfg_grp[l]), 4'(cfg_sh[l])};
        end
        ptr = 0;
        for (int l = 0; l < n_layers; l++) begin
            for (int n = 0; n < cfg_ic[l] * cfg_grp[l]; n++) begin
                for (int k = 0; k < `PU_LANES; k++) begin
                    if (clip_first && l == 0) w[k*`PU_WGT_W +: `PU_WGT_W] = k[0] ? 8'h80 : 8'h7f;
                    else w[k*`PU_WGT_W +: `PU_WGT_W] = 8'(rand_signed(wgt_bits));
                end
                @(negedge clk);
                cfg_we    = 1'b0;
                wgt_we    = 1'b1;
                wgt_addr  = waddr_t'(ptr);
                wgt_data  = w;
                wmem[ptr] = w;
                ptr++;
            end
        end
        @(negedge clk);
        wgt_we     = 1'b0;
        start      = 1'b1;
        num_layers = layer_t'(n_layers);
        @(negedge clk);
        start  = 1'b0;
        in_run = 1'b1;
        ptr    = 0;
        for (int l = 0; l < n_layers; l++) begin
            for (int g = 0; g < cfg_grp[l]; g++) begin
                for (int c = 0; c < cfg_ic[l]; c++) begin
                    @(negedge clk);
                    if (gaps && rand_bits(1)) begin
                        in_valid = 1'b0;
                        @(negedge clk);
                    end
                    a        = (clip_first && l == 0) ? 127 : rand_signed(act_bits);
                    in_valid = 1'b1;
                    in_act   = act_t'(a);
                    start    = restart_mid && ptr == 2;   // Ignored while a run is active.
                    for (int k = 0; k < `PU_LANES; k++) begin
                        if (c == 0) acc[k] = 0;
                        acc[k] += a * int'($signed(wmem[ptr][k*`PU_WGT_W +: `PU_WGT_W]));
                    end
                    if (c == cfg_ic[l] - 1) begin
                        for (int k = 0; k < `PU_LANES; k++) begin
                            b.data     = sat_shift(acc[k], cfg_sh[l]);
                            b.lane     = k;
                            b.layer    = l;
                            b.grp      = g;
                            b.at_cycle = cyc + 3 + k;
                            exp_q.push_back(b);
                        end
                    end
                    done_edge = cyc + 7;
                    ptr++;
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        start    = 1'b0;
        for (int i = 0; i < 20 && in_run; i++) begin
            @(negedge clk);
        end
        assert (!in_run) else report_error("done did not arrive after the last activation");
        in_run = 1'b0;
        assert (exp_q.size() == 0) else report_error("results are missing from the output");
        exp_q.delete();
    endtask

    // Output checks at the rising edge.
    always @(posedge clk) begin : check_outputs
        beat_t b;
        if (!reset) begin
            if (out_valid) begin
                assert (exp_q.size() != 0)
                    else report_error("an output beat appeared with no result expected");
                if (exp_q.size() != 0) begin
                    b = exp_q.pop_front();
                    assert (cyc == b.at_cycle) else report_mismatch("beat cycle", b.at_cycle, cyc);
                    assert (int'(out_data) == b.data)
                        else report_mismatch("data", b.data, out_data);
                    assert (int'(out_lane) == b.lane)
                        else report_mismatch("lane", b.lane, out_lane);
                    assert (int'(out_layer) == b.layer)
                        else report_mismatch("layer", b.layer, out_layer);
                    assert (int'(out_grp) == b.grp) else report_mismatch("group", b.grp, out_grp);
                end
            end
            if (in_run) begin
                assert (busy) else report_error("busy dropped while a run was active");
            end else begin
                assert (!busy && !done) else report_error("busy or done rose with no run");
            end
            if (done) begin
                done_count++;
                assert (cyc == done_edge) else report_mismatch("done cycle", done_edge, cyc);
                in_run = 1'b0;
            end
        end
        cyc <= cyc + 1;
    end

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else report_error("done stayed high for more than one cycle");
    beat_in_run: assert property (@(posedge clk) disable iff (reset) out_valid |-> busy)
        else report_error("an output beat came while not busy");

    initial begin
        reset      = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_data   = '0;
        wgt_we     = 1'b0;
        wgt_addr   = '0;
        wgt_data   = '0;
        start      = 1'b0;
        num_layers = '0;
        in_valid   = 1'b0;
        in_act     = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        begin_test("idle_inputs");
        repeat (16) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_act   = act_t'(rand_bits(8));
        end
        @(negedge clk);
        in_valid = 1'b0;
        repeat (10) @(negedge clk);
        end_test();

        begin_test("single_group");
        set_layer(0, 8, 1, 0);
        run_layers(1, 6, 4, 0, 0, 0);
        end_test();

        begin_test("shift_saturate");
        set_layer(0, 5, 1, 0);   // Fixed pattern that clips both ways.
        for (int l = 1; l < 8; l++) set_layer(l, 5, 1, l);
        run_layers(8, 8, 8, 1, 0, 0);
        end_test();

        begin_test("three_layers");
        set_layer(0, 6, 2, 2);
        set_layer(1, 4, 3, 1);
        set_layer(2, 9, 1, 3);
        run_layers(3, 6, 5, 0, 1, 0);
        end_test();

        begin_test("back_to_back");
        set_layer(0, 4, 6, 1);
        run_layers(1, 7, 6, 0, 0, 0);
        end_test();

        begin_test("done_and_busy");
        done_count = 0;
        set_layer(0, 4, 2, 0);
        run_layers(1, 6, 4, 0, 0, 1);
        assert (done_count == 1) else report_mismatch("done pulses", 1, done_count);
        end_test();

        $display("Tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (err_count == 0 && fail_tests == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/pu_pkg.sv
design/pe_bus_if.sv
design/pu_controller.sv
design/act_distributor.sv
design/mac_lane.sv
design/result_collector.sv
design/pu_top.sv
tb/pu_tb.sv

/* Bender.yml */
package:
  name: pu

sources:
  - include_dirs:
      - design
    files:
      - design/pu_pkg.sv
      - design/pe_bus_if.sv
      - design/pu_controller.sv
      - design/act_distributor.sv
      - design/mac_lane.sv
      - design/result_collector.sv
      - design/pu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/pu_tb.sv
